// ==== files.f ====
+incdir+design
+incdir+sim
design/vid_pkg.sv
design/extout_pkg.sv
design/vid_stream_if.sv
design/osd_mixer.sv
design/ypbpr_csc.sv
design/analog_out_fmt.sv
design/video_out_top.sv
sim/tb_video_out.sv

// ==== sim/video_out_model.svh ====
////////////////////////////////////////////////////////////
// Reference model: OSD palette, YPbPr CSC, sync formatting
////////////////////////////////////////////////////////////
`ifndef VIDEO_OUT_MODEL_SVH
`define VIDEO_OUT_MODEL_SVH

`include "vid_out_config.svh"

function automatic logic [23:0] osd_palette(input logic [1:0] color);
    case (color)
        2'd0:    return `VID_OSD_C0;
        2'd1:    return `VID_OSD_C1;
        2'd2:    return `VID_OSD_C2;
        default: return `VID_OSD_C3;
    endcase
endfunction

// One output channel: weighted sum, arithmetic shift, offset, clamp
function automatic logic [`VID_PIX_W-1:0] csc_chan(
    input int r, input int g, input int b,
    input int cr, input int cg, input int cb, input int off
);
    int acc;
    acc = (r * cr + g * cg + b * cb) >>> `VID_CSC_SHIFT;
    acc = acc + off;
    if (acc < 0)
        return '0;
    if (acc > (1 << `VID_PIX_W) - 1)
        return '1;
    return acc[`VID_PIX_W-1:0];
endfunction

function automatic logic [23:0] csc_pixel(input logic [23:0] rgb);
    int r, g, b;
    logic [7:0] y, pb, pr;
    r  = rgb[23:16];
    g  = rgb[15:8];
    b  = rgb[7:0];
    y  = csc_chan(r, g, b, `VID_CSC_Y_R, `VID_CSC_Y_G, `VID_CSC_Y_B, 0);
    pb = csc_chan(r, g, b, `VID_CSC_PB_R, `VID_CSC_PB_G, `VID_CSC_PB_B, `VID_CSC_OFFSET);
    pr = csc_chan(r, g, b, `VID_CSC_PR_R, `VID_CSC_PR_G, `VID_CSC_PR_B, `VID_CSC_OFFSET);
    // Pr on red, Y on green, Pb on blue
    return {pr, y, pb};
endfunction

// Returns {hs, vs, blank_n, sync_n}
function automatic logic [3:0] fmt_syncs(
    input logic [1:0] mode, input logic hs, input logic vs, input logic de
);
    logic cs;
    cs = ~(hs ^ vs);
    case (mode)
        OUT_RGBHV: return {hs, vs, de, 1'b0};
        OUT_RGBCS: return {cs, 1'b1, de, 1'b0};
        OUT_RGSB:  return {cs, 1'b1, de, cs};
        default:   return {cs, 1'b1, 1'b1, cs};
    endcase
endfunction

`endif

// ==== sim/tb_video_out.sv ====
////////////////////////////////////////////////////////////
// Testbench for the video output path, table driven
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vid_out_config.svh"

module tb_video_out;
    import vid_pkg::*;
    import extout_pkg::*;

    `include "video_out_model.svh"

    localparam int CLK_HALF   = 4;
    localparam int RESET_CYC  = 5;
    localparam int DRIVE_DLY  = 1;
    localparam int HDMI_LAT   = 2;
    localparam int VGA_LAT    = 5;
    localparam int SETTLE_CYC = 5;
    localparam int N_SEGS     = 13;

    typedef struct packed {
        logic [1:0] exp_sel;
        logic [1:0] mode;
        logic       osd_en;
        logic [1:0] osd_col;
        logic [7:0] len;
        logic       rnd_ctl;
    } seg_t;

    // exp_sel, mode, osd_en, osd_col, pixels, random de and syncs
    localparam seg_t SEGS [N_SEGS] = '{
        '{EXP_EXTRA_OUT, OUT_RGBHV, 1'b0, OSD_BLACK,  8'd40, 1'b1},
        '{EXP_EXTRA_OUT, OUT_RGBHV, 1'b1, OSD_BLACK,  8'd16, 1'b1},
        '{EXP_EXTRA_OUT, OUT_RGBCS, 1'b1, OSD_BLUE,   8'd16, 1'b1},
        '{EXP_EXTRA_OUT, OUT_RGSB,  1'b1, OSD_YELLOW, 8'd16, 1'b1},
        '{EXP_EXTRA_OUT, OUT_RGBCS, 1'b0, OSD_BLACK,  8'd32, 1'b1},
        '{EXP_EXTRA_OUT, OUT_RGSB,  1'b0, OSD_BLACK,  8'd32, 1'b1},
        '{EXP_EXTRA_OUT, OUT_YPBPR, 1'b0, OSD_BLACK,  8'd48, 1'b1},
        '{EXP_EXTRA_OUT, OUT_YPBPR, 1'b1, OSD_WHITE,  8'd16, 1'b1},
        '{EXP_OFF,       OUT_YPBPR, 1'b0, OSD_BLACK,  8'd24, 1'b1},
        '{EXP_LEGACY_IN, OUT_RGBHV, 1'b0, OSD_BLACK,  8'd24, 1'b1},
        '{EXP_EXTRA_OUT, OUT_RGBHV, 1'b0, OSD_BLACK,  8'd16, 1'b0},
        '{EXP_UVC_BDG,   OUT_RGBCS, 1'b1, OSD_BLUE,   8'd24, 1'b1},
        '{EXP_EXTRA_OUT, OUT_YPBPR, 1'b0, OSD_BLACK,  8'd24, 1'b0}
    };

    logic       pclk_out, po_reset_n;
    logic [7:0] r_i, g_i, b_i;
    logic       hsync_i, vsync_i, de_i, osd_enable_i;
    logic [1:0] osd_color_i, exp_sel_i, extra_out_mode_i;
    logic [7:0] hdmi_r_o, hdmi_g_o, hdmi_b_o, vga_r_o, vga_g_o, vga_b_o;
    logic       hdmi_hsync_o, hdmi_vsync_o, hdmi_de_o;
    logic       vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o, ext_oe_o;

    // Expected {rgb, hs, vs, de} and {rgb, hs, vs, blank_n, sync_n}
    logic [26:0] hdmi_q [$];
    logic [27:0] vga_q [$];
    int n_checks = 0;
    int n_errors = 0;

    video_out_top u_dut (.*);

    initial begin
        pclk_out = 1'b0;
        forever #CLK_HALF pclk_out = ~pclk_out;
    end

    task automatic check_value(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_hdmi(input logic [26:0] exp);
        check_value("{hdmi_r_o,hdmi_g_o,hdmi_b_o}", {hdmi_r_o, hdmi_g_o, hdmi_b_o}, exp[26:3]);
        check_value("hdmi_hsync_o", hdmi_hsync_o, exp[2]);
        check_value("hdmi_vsync_o", hdmi_vsync_o, exp[1]);
        check_value("hdmi_de_o", hdmi_de_o, exp[0]);
    endtask

    task automatic check_vga(input logic [27:0] exp);
        check_value("{vga_r_o,vga_g_o,vga_b_o}", {vga_r_o, vga_g_o, vga_b_o}, exp[27:4]);
        check_value("vga_hs_o", vga_hs_o, exp[3]);
        check_value("vga_vs_o", vga_vs_o, exp[2]);
        check_value("vga_blank_n_o", vga_blank_n_o, exp[1]);
        check_value("vga_sync_n_o", vga_sync_n_o, exp[0]);
    endtask

    initial begin
        seg_t        seg;
        logic [31:0] rnd;
        logic [23:0] pix, mix;
        logic        hs, vs, de;
        logic [26:0] h_exp;
        logic [27:0] held;
        logic [1:0]  cur_exp;
        int          skip;

        void'($urandom(50868));
        held    = '0;
        cur_exp = EXP_OFF;
        po_reset_n = 1'b0;
        {r_i, g_i, b_i} = '0;
        {hsync_i, vsync_i, de_i, osd_enable_i} = '0;
        osd_color_i      = OSD_BLACK;
        exp_sel_i        = EXP_OFF;
        extra_out_mode_i = OUT_RGBHV;
        repeat (RESET_CYC) @(posedge pclk_out);
        #DRIVE_DLY po_reset_n = 1'b1;

        // Reset values at the first edge after release
        @(posedge pclk_out);
        #DRIVE_DLY;
        check_hdmi('0);
        check_vga('0);

        for (int s = 0; s < N_SEGS; s++) begin
            seg  = SEGS[s];
            skip = SETTLE_CYC;
            for (int p = 0; p < seg.len; p++) begin
                @(posedge pclk_out);
                #DRIVE_DLY;
                if (hdmi_q.size() == HDMI_LAT) begin
                    h_exp = hdmi_q.pop_front();
                    if (skip == 0)
                        check_hdmi(h_exp);
                end
                // Analog pins freeze while the port is not an output
                if (vga_q.size() == VGA_LAT) begin
                    if (cur_exp == EXP_EXTRA_OUT)
                        held = vga_q.pop_front();
                    else
                        void'(vga_q.pop_front());
                end
                if (skip == 0)
                    check_vga(held);
                check_value("ext_oe_o", ext_oe_o, cur_exp == EXP_EXTRA_OUT);
                if (skip > 0)
                    skip--;

                rnd = $urandom;
                pix = rnd[23:0];
                {hs, vs, de} = seg.rnd_ctl ? rnd[26:24] : 3'b001;
                {r_i, g_i, b_i} = pix;
                {hsync_i, vsync_i, de_i} = {hs, vs, de};
                osd_enable_i     = seg.osd_en;
                osd_color_i      = seg.osd_col;
                exp_sel_i        = seg.exp_sel;
                extra_out_mode_i = seg.mode;
                cur_exp          = seg.exp_sel;

                mix = seg.osd_en ? osd_palette(seg.osd_col) : pix;
                hdmi_q.push_back({mix, hs, vs, de});
                vga_q.push_back({(seg.mode == OUT_YPBPR) ? csc_pixel(mix) : mix,
                                 fmt_syncs(seg.mode, hs, vs, de)});
            end
        end

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog sized from the stimulus table
    initial begin
        int limit;
        limit = RESET_CYC + 100;
        for (int s = 0; s < N_SEGS; s++)
            limit += SEGS[s].len;
        repeat (limit) @(posedge pclk_out);
        $display("Timeout: the run was still going after %0d clock cycles", limit);
        $display("tests failed");
        $finish;
    end

endmodule

// ==== design/video_out_top.sv ====
////////////////////////////////////////////////////////////
// Pixel-clock output path: OSD, HDMI pins, analog output
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vid_out_config.svh"

module video_out_top (
    input  logic                  pclk_out,
    input  logic                  po_reset_n,
    input  logic [`VID_PIX_W-1:0] r_i,
    input  logic [`VID_PIX_W-1:0] g_i,
    input  logic [`VID_PIX_W-1:0] b_i,
    input  logic                  hsync_i,
    input  logic                  vsync_i,
    input  logic                  de_i,
    input  logic                  osd_enable_i,
    input  logic [1:0]            osd_color_i,
    input  logic [1:0]            exp_sel_i,
    input  logic [1:0]            extra_out_mode_i,
    output logic [`VID_PIX_W-1:0] hdmi_r_o,
    output logic [`VID_PIX_W-1:0] hdmi_g_o,
    output logic [`VID_PIX_W-1:0] hdmi_b_o,
    output logic                  hdmi_hsync_o,
    output logic                  hdmi_vsync_o,
    output logic                  hdmi_de_o,
    output logic [`VID_PIX_W-1:0] vga_r_o,
    output logic [`VID_PIX_W-1:0] vga_g_o,
    output logic [`VID_PIX_W-1:0] vga_b_o,
    output logic                  vga_hs_o,
    output logic                  vga_vs_o,
    output logic                  vga_blank_n_o,
    output logic                  vga_sync_n_o,
    output logic                  ext_oe_o
);
    import vid_pkg::*;
    import extout_pkg::*;

    rgb_t pix_in;
    rgb_t hdmi_pix;
    rgb_t vga_pix;

    vid_stream_if s_mix ();
    vid_stream_if s_csc ();

    assign pix_in = '{r: r_i, g: g_i, b: b_i};

    osd_mixer u_osd_mixer (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .pix_i        (pix_in),
        .hsync_i      (hsync_i),
        .vsync_i      (vsync_i),
        .de_i         (de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_e'(osd_color_i)),
        .mix_o        (s_mix),
        .hdmi_pix_o   (hdmi_pix),
        .hdmi_hsync_o (hdmi_hsync_o),
        .hdmi_vsync_o (hdmi_vsync_o),
        .hdmi_de_o    (hdmi_de_o)
    );

    ypbpr_csc u_ypbpr_csc (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .extra_out_mode_i (extra_out_mode_e'(extra_out_mode_i)),
        .in_s             (s_mix),
        .out_s            (s_csc)
    );

    analog_out_fmt u_analog_out_fmt (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .exp_sel_i        (exp_sel_e'(exp_sel_i)),
        .extra_out_mode_i (extra_out_mode_e'(extra_out_mode_i)),
        .in_s             (s_csc),
        .vga_pix_o        (vga_pix),
        .vga_hs_o         (vga_hs_o),
        .vga_vs_o         (vga_vs_o),
        .vga_blank_n_o    (vga_blank_n_o),
        .vga_sync_n_o     (vga_sync_n_o),
        .ext_oe_o         (ext_oe_o)
    );

    assign hdmi_r_o = hdmi_pix.r;
    assign hdmi_g_o = hdmi_pix.g;
    assign hdmi_b_o = hdmi_pix.b;

    assign vga_r_o = vga_pix.r;
    assign vga_g_o = vga_pix.g;
    assign vga_b_o = vga_pix.b;

endmodule

// ==== design/analog_out_fmt.sv ====
////////////////////////////////////////////////////////////
// Analog DAC formatting: syncs, blank, sync-on-green
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module analog_out_fmt (
    input  logic                         pclk_out,
    input  logic                         po_reset_n,
    input  extout_pkg::exp_sel_e         exp_sel_i,
    input  extout_pkg::extra_out_mode_e  extra_out_mode_i,
    vid_stream_if.dst                    in_s,
    output vid_pkg::rgb_t                vga_pix_o,
    output logic                         vga_hs_o,
    output logic                         vga_vs_o,
    output logic                         vga_blank_n_o,
    output logic                         vga_sync_n_o,
    output logic                         ext_oe_o
);
    import vid_pkg::*;
    import extout_pkg::*;

    logic csync;
    logic advance;
    rgb_t pix_pre;
    logic hs_pre, vs_pre, blank_n_pre, sync_n_pre;

    assign csync = ~(in_s.hsync ^ in_s.vsync);

    // Pins only driven when the expansion port is an output
    assign advance  = (exp_sel_i == EXP_EXTRA_OUT);
    assign ext_oe_o = advance;

    // Stage 1, format per output mode
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pix_pre     <= '0;
            hs_pre      <= 1'b0;
            vs_pre      <= 1'b0;
            blank_n_pre <= 1'b0;
            sync_n_pre  <= 1'b0;
        end else if (advance) begin
            pix_pre     <= in_s.pix;
            hs_pre      <= (extra_out_mode_i == OUT_RGBHV) ? in_s.hsync : csync;
            vs_pre      <= (extra_out_mode_i == OUT_RGBHV) ? in_s.vsync : 1'b1;
            blank_n_pre <= (extra_out_mode_i == OUT_YPBPR) ? 1'b1 : in_s.de;
            // sync on green in RGsB and on Y in YPbPr
            sync_n_pre  <= (extra_out_mode_i == OUT_RGSB || extra_out_mode_i == OUT_YPBPR) ?
                           csync : 1'b0;
        end
    end

    // Stage 2, DAC register
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vga_pix_o     <= '0;
            vga_hs_o      <= 1'b0;
            vga_vs_o      <= 1'b0;
            vga_blank_n_o <= 1'b0;
            vga_sync_n_o  <= 1'b0;
        end else if (advance) begin
            vga_pix_o     <= pix_pre;
            vga_hs_o      <= hs_pre;
            vga_vs_o      <= vs_pre;
            vga_blank_n_o <= blank_n_pre;
            vga_sync_n_o  <= sync_n_pre;
        end
    end

    ext_oe_a: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        ext_oe_o == (exp_sel_i == EXP_EXTRA_OUT)
    ) else $error("ext_oe_o does not match exp_sel_i");

endmodule

// ==== design/ypbpr_csc.sv ====
////////////////////////////////////////////////////////////
// RGB to YPbPr converter, two stages, RGB bypass otherwise
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vid_out_config.svh"

module ypbpr_csc (
    input  logic                         pclk_out,
    input  logic                         po_reset_n,
    input  extout_pkg::extra_out_mode_e  extra_out_mode_i,
    vid_stream_if.dst                    in_s,
    vid_stream_if.src                    out_s
);
    import vid_pkg::*;
    import extout_pkg::*;

    logic signed [`VID_PIX_W:0]       r_s, g_s, b_s;
    logic signed [`VID_CSC_ACC_W-1:0] y_acc_d, pb_acc_d, pr_acc_d;
    logic signed [`VID_CSC_ACC_W-1:0] y_acc_q, pb_acc_q, pr_acc_q;
    rgb_t rgb_q;
    logic hsync_q, vsync_q, de_q;

    // Shift back to pixel scale, optional chroma offset, clamp
    function automatic logic [`VID_PIX_W-1:0] csc_clamp(
        input logic signed [`VID_CSC_ACC_W-1:0] acc,
        input logic                             add_off
    );
        logic signed [`VID_CSC_ACC_W-1:0] val;
        val = (acc >>> `VID_CSC_SHIFT) + (add_off ? `VID_CSC_OFFSET : 10'sd0);
        if (val < 0)
            return '0;
        else if (val > ((1 << `VID_PIX_W) - 1))
            return '1;
        else
            return val[`VID_PIX_W-1:0];
    endfunction

    // Channels are unsigned, extend before the signed multiply
    assign r_s = {1'b0, in_s.pix.r};
    assign g_s = {1'b0, in_s.pix.g};
    assign b_s = {1'b0, in_s.pix.b};

    always_comb begin
        y_acc_d  = r_s * `VID_CSC_Y_R  + g_s * `VID_CSC_Y_G  + b_s * `VID_CSC_Y_B;
        pb_acc_d = r_s * `VID_CSC_PB_R + g_s * `VID_CSC_PB_G + b_s * `VID_CSC_PB_B;
        pr_acc_d = r_s * `VID_CSC_PR_R + g_s * `VID_CSC_PR_G + b_s * `VID_CSC_PR_B;
    end

    // Stage 1, products and sums
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            y_acc_q  <= '0;
            pb_acc_q <= '0;
            pr_acc_q <= '0;
            rgb_q    <= '0;
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            de_q     <= 1'b0;
        end else begin
            y_acc_q  <= y_acc_d;
            pb_acc_q <= pb_acc_d;
            pr_acc_q <= pr_acc_d;
            rgb_q    <= in_s.pix;
            hsync_q  <= in_s.hsync;
            vsync_q  <= in_s.vsync;
            de_q     <= in_s.de;
        end
    end

    // Stage 2. In YPbPr, G carries Y, B carries Pb and R carries Pr
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            out_s.pix   <= '0;
            out_s.hsync <= 1'b0;
            out_s.vsync <= 1'b0;
            out_s.de    <= 1'b0;
        end else begin
            if (extra_out_mode_i == OUT_YPBPR) begin
                out_s.pix.r <= csc_clamp(pr_acc_q, 1'b1);
                out_s.pix.g <= csc_clamp(y_acc_q, 1'b0);
                out_s.pix.b <= csc_clamp(pb_acc_q, 1'b1);
            end else begin
                out_s.pix <= rgb_q;
            end
            out_s.hsync <= hsync_q;
            out_s.vsync <= vsync_q;
            out_s.de    <= de_q;
        end
    end

    de_latency_a: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        out_s.de == $past(in_s.de, 2)
    ) else $error("CSC de is not delayed by two cycles");

endmodule

// ==== design/osd_mixer.sv ====
////////////////////////////////////////////////////////////
// OSD palette overlay and two-stage HDMI output register
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "vid_out_config.svh"

module osd_mixer (
    input  logic                 pclk_out,
    input  logic                 po_reset_n,
    input  vid_pkg::rgb_t        pix_i,
    input  logic                 hsync_i,
    input  logic                 vsync_i,
    input  logic                 de_i,
    input  logic                 osd_enable_i,
    input  vid_pkg::osd_color_e  osd_color_i,
    vid_stream_if.src            mix_o,
    output vid_pkg::rgb_t        hdmi_pix_o,
    output logic                 hdmi_hsync_o,
    output logic                 hdmi_vsync_o,
    output logic                 hdmi_de_o
);
    import vid_pkg::*;

    rgb_t osd_pix;

    // Palette lookup
    always_comb begin
        case (osd_color_i)
            OSD_BLACK:  osd_pix = `VID_OSD_C0;
            OSD_BLUE:   osd_pix = `VID_OSD_C1;
            OSD_YELLOW: osd_pix = `VID_OSD_C2;
            default:    osd_pix = `VID_OSD_C3;
        endcase
    end

    // Stage 1, overlay result
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            mix_o.pix   <= '0;
            mix_o.hsync <= 1'b0;
            mix_o.vsync <= 1'b0;
            mix_o.de    <= 1'b0;
        end else begin
            mix_o.pix   <= osd_enable_i ? osd_pix : pix_i;
            mix_o.hsync <= hsync_i;
            mix_o.vsync <= vsync_i;
            mix_o.de    <= de_i;
        end
    end

    // Stage 2, launch to transmitter pins
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_pix_o   <= '0;
            hdmi_hsync_o <= 1'b0;
            hdmi_vsync_o <= 1'b0;
            hdmi_de_o    <= 1'b0;
        end else begin
            hdmi_pix_o   <= mix_o.pix;
            hdmi_hsync_o <= mix_o.hsync;
            hdmi_vsync_o <= mix_o.vsync;
            hdmi_de_o    <= mix_o.de;
        end
    end

    osd_color_known_a: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        osd_enable_i |-> !$isunknown(osd_color_i)
    ) else $error("osd_color_i unknown while OSD is enabled");

endmodule

// ==== design/vid_stream_if.sv ====
////////////////////////////////////////////////////////////
// Pixel stream with syncs and data enable, no handshake
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface vid_stream_if;
    import vid_pkg::*;

    rgb_t pix;
    logic hsync;
    logic vsync;
    logic de;

    modport src (
        output pix,
        output hsync,
        output vsync,
        output de
    );

    modport dst (
        input pix,
        input hsync,
        input vsync,
        input de
    );

endinterface

// ==== design/extout_pkg.sv ====
////////////////////////////////////////////////////////////
// Expansion port and extra analog output modes
////////////////////////////////////////////////////////////
package extout_pkg;

    // Expansion port function
    typedef enum logic [1:0] {
        EXP_OFF       = 2'd0,
        EXP_EXTRA_OUT = 2'd1,
        EXP_LEGACY_IN = 2'd2,
        EXP_UVC_BDG   = 2'd3
    } exp_sel_e;

    // Analog output format
    typedef enum logic [1:0] {
        OUT_RGBHV = 2'd0,
        OUT_RGBCS = 2'd1,
        OUT_RGSB  = 2'd2,
        OUT_YPBPR = 2'd3
    } extra_out_mode_e;

endpackage

// ==== design/vid_pkg.sv ====
////////////////////////////////////////////////////////////
// Video stream types shared by the output path
////////////////////////////////////////////////////////////
`include "vid_out_config.svh"

package vid_pkg;

    // One RGB pixel
    typedef struct packed {
        logic [`VID_PIX_W-1:0] r;
        logic [`VID_PIX_W-1:0] g;
        logic [`VID_PIX_W-1:0] b;
    } rgb_t;

    // OSD palette index
    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

endpackage

// ==== design/vid_out_config.svh ====
////////////////////////////////////////////////////////////
// Video output config: pixel width, OSD palette, CSC
////////////////////////////////////////////////////////////
`ifndef VID_OUT_CONFIG_SVH
`define VID_OUT_CONFIG_SVH

`define VID_PIX_W 8

// OSD palette, packed as {r, g, b}
`define VID_OSD_C0 24'h000000
`define VID_OSD_C1 24'h0000ff
`define VID_OSD_C2 24'hffff00
`define VID_OSD_C3 24'hffffff

// CSC coefficients, scale of 256
`define VID_CSC_Y_R  (9'sd77)
`define VID_CSC_Y_G  (9'sd150)
`define VID_CSC_Y_B  (9'sd29)
`define VID_CSC_PB_R (-9'sd43)
`define VID_CSC_PB_G (-9'sd85)
`define VID_CSC_PB_B (9'sd128)
`define VID_CSC_PR_R (9'sd128)
`define VID_CSC_PR_G (-9'sd107)
`define VID_CSC_PR_B (-9'sd21)

`define VID_CSC_SHIFT  8
`define VID_CSC_OFFSET (10'sd128)
// Sum of three 9x9 signed products
`define VID_CSC_ACC_W  18

`endif
